//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "sim passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

//--- source/sdram_arbiter.sv
// command bus arbiter
`default_nettype none

module sdram_arbiter
    import sdram_cmd_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          init,
    input  sdram_cmd_t    init_cmd,
    input  sdram_a_t      init_a,
    sdram_bus_if.arbiter  bus [4],
    input  logic [3:0]    dbusy,
    input  logic [3:0]    post_act,
    output logic          data_busy,
    output logic          act_recent,
    output sdram_cmd_t    cmd,
    output sdram_a_t      sdram_a,
    output sdram_ba_t     sdram_ba
);
    logic [14:0] lfsr;
    logic [1:0]  prio;
    logic [3:0]  br;
    logic [3:0]  bg;
    logic [1:0]  sel;
    logic        hit;
    sdram_cmd_t  bx_cmd [4];
    sdram_a_t    bx_a [4];
    sdram_cmd_t  next_cmd;
    sdram_a_t    next_a;
    sdram_ba_t   next_ba;

    for (genvar i = 0; i < 4; i++) begin : g_bus
        assign br[i]     = bus[i].br;
        assign bx_cmd[i] = bus[i].cmd;
        assign bx_a[i]   = bus[i].a;
        assign bus[i].bg = bg[i];
    end

    assign data_busy  = |dbusy;
    assign act_recent = |post_act;
    assign prio       = lfsr[1:0];

    // first requester going round from prio
    always_comb begin
        logic [1:0] idx;
        bg  = '0;
        sel = '0;
        hit = 1'b0;
        for (int k = 0; k < 4; k++) begin
            idx = prio + 2'(k);
            if (!hit && br[idx]) begin
                sel = idx;
                hit = 1'b1;
            end
        end
        if (!init && hit) begin
            bg[sel] = 1'b1;
        end
    end

    always_comb begin
        if (init) begin
            next_cmd = init_cmd;
            next_a   = init_a;
            next_ba  = '0;
        end else if (hit) begin
            next_cmd = bx_cmd[sel];
            next_a   = bx_a[sel];
            next_ba  = sel;
        end else begin
            next_cmd = NOP;
            next_a   = '0;
            next_ba  = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= 15'd1;
            cmd  <= NOP;
        end else begin
            lfsr <= {lfsr[13:0], lfsr[14] ^ lfsr[13]};  // x^15 + x^14 + 1
            cmd  <= next_cmd;
        end
    end

    always_ff @(posedge clk) begin
        sdram_ba      <= next_ba;
        sdram_a[10:0] <= next_a[10:0];
        // upper address bits double as DQM
        if (next_cmd inside {LOAD_MODE, ACTIVE, READ, WRITE}) begin
            sdram_a[12:11] <= next_a[12:11];
        end else begin
            sdram_a[12:11] <= 2'b00;
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_bank.sv
// per-bank request controller
`default_nettype none
`include "sdram_config.svh"

module sdram_bank
    import sdram_cmd_pkg::*;
    import sdram_bank_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  req_addr_t  addr,
    input  logic       rd,
    input  logic       wr,
    output logic       ack,
    output logic       dst,
    output logic       dok,
    output logic       rdy,
    output logic       dbusy,
    output logic       post_act,
    input  logic       data_busy,
    input  logic       act_recent,
    sdram_bus_if.bank  bus
);
    localparam int CL = `SDRAM_CL;
    localparam int PL = CL + 3;   // grant+1 up to the last read word on dout

    bank_state_t   state;
    logic [PL-1:0] pipe;          // bit k is high k+1 cycles after the column grant
    logic [3:0]    cnt;
    logic          is_wr;
    logic          granted;

    assign granted = bus.br && bus.bg;

    // request and command towards the arbiter
    always_comb begin
        bus.cmd = NOP;
        bus.a   = '0;
        bus.br  = 1'b0;
        case (state)
            ACT_REQ: begin
                bus.cmd = ACTIVE;
                bus.a   = addr[`SDRAM_AW-1 -: 13];
                // row bits reach the DQM pins, keep them off read data
                bus.br  = !act_recent && !data_busy;
            end
            COL_REQ: begin
                bus.cmd = is_wr ? WRITE : READ;
                bus.a   = {2'b00, 1'b1, 1'b0, addr[8:0]};  // A10 for auto-precharge
                bus.br  = !data_busy;
            end
            default: begin
                bus.br = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pipe     <= '0;
            cnt      <= '0;
            is_wr    <= 1'b0;
            ack      <= 1'b0;
            post_act <= 1'b0;
        end else begin
            ack      <= granted && state == COL_REQ;
            post_act <= granted && state == ACT_REQ;
            pipe     <= {pipe[PL-2:0], granted && state == COL_REQ};
            case (state)
                IDLE: begin
                    if (rd || wr) begin
                        is_wr <= wr;
                        state <= ACT_REQ;
                    end
                end
                ACT_REQ: begin
                    if (granted) begin
                        cnt   <= 4'(`SDRAM_TRCD - 2);
                        state <= RCD_WAIT;
                    end
                end
                RCD_WAIT: begin
                    if (cnt == '0) begin
                        state <= COL_REQ;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                COL_REQ: begin
                    if (granted) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    // writes also sit here, which covers write recovery
                    if (pipe[CL+1]) begin
                        cnt   <= 4'(`SDRAM_TRP - 1);
                        state <= PRE_WAIT;
                    end
                end
                PRE_WAIT: begin
                    if (cnt == '0) begin
                        state <= IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a write has no data latency
    assign dst   = is_wr ? pipe[1] : pipe[CL];
    assign dok   = is_wr ? pipe[1] : pipe[CL+1] | pipe[CL+2];
    assign rdy   = is_wr ? pipe[1] : pipe[CL+2];
    assign dbusy = is_wr ? pipe[0] : |pipe[CL+1:0];  // command cycle to last word on dq

endmodule

`default_nettype wire

//--- source/sdram_bank_pkg.sv
// request side types
`default_nettype none
`include "sdram_config.svh"

package sdram_bank_pkg;

    typedef logic [`SDRAM_AW-1:0] req_addr_t; // row on top, 9-bit column below

    typedef enum logic [2:0] {
        IDLE,
        ACT_REQ,
        RCD_WAIT,
        COL_REQ,
        DATA,
        PRE_WAIT
    } bank_state_t;

    typedef logic [1:0] wmask_t; // set bit keeps that byte

endpackage

`default_nettype wire

//--- source/sdram_bus_if.sv
// bank to arbiter command channel
`default_nettype none

interface sdram_bus_if
    import sdram_cmd_pkg::*;
();
    logic       br;  // bus request
    logic       bg;  // grant, same cycle as br
    sdram_cmd_t cmd;
    sdram_a_t   a;

    modport bank (
        output br,
        output cmd,
        output a,
        input  bg
    );

    modport arbiter (
        input  br,
        input  cmd,
        input  a,
        output bg
    );

endinterface

`default_nettype wire

//--- source/sdram_cmd_pkg.sv
// SDRAM device side types
`default_nettype none

package sdram_cmd_pkg;

    // bits are /CS /RAS /CAS /WE
    typedef enum logic [3:0] {
        LOAD_MODE = 4'b0000,
        REFRESH   = 4'b0001,
        PRECHARGE = 4'b0010,
        ACTIVE    = 4'b0011,
        WRITE     = 4'b0100,
        READ      = 4'b0101,
        STOP      = 4'b0110, // burst terminate
        NOP       = 4'b0111,
        INHIBIT   = 4'b1000
    } sdram_cmd_t;

    typedef logic [12:0] sdram_a_t;
    typedef logic [1:0]  sdram_ba_t;
    typedef logic [15:0] sdram_dq_t;

endpackage

`default_nettype wire

//--- source/sdram_config.svh
// SDRAM controller parameters
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// request word address, row bits above column bits
`define SDRAM_AW        22

// device timing in clock cycles
`define SDRAM_CL        2
`define SDRAM_TRCD      2
`define SDRAM_TRP       2
`define SDRAM_TRFC      7

// power-up wait, short for simulation
`define SDRAM_INIT_WAIT 100

// burst of 2, sequential, CAS latency 2
`define SDRAM_MODE      13'h021

`endif

//--- source/sdram_ctrl.sv
// four-bank SDRAM controller
`default_nettype none

module sdram_ctrl
    import sdram_cmd_pkg::*;
    import sdram_bank_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  req_addr_t   ba0_addr,
    input  req_addr_t   ba1_addr,
    input  req_addr_t   ba2_addr,
    input  req_addr_t   ba3_addr,
    input  logic [3:0]  rd,
    input  logic [3:0]  wr,
    input  sdram_dq_t   din,
    input  wmask_t      din_m,
    output logic [3:0]  ack,
    output logic [3:0]  dst,
    output logic [3:0]  dok,
    output logic [3:0]  rdy,
    output sdram_dq_t   dout,
    inout  wire  [15:0] sdram_dq,
    output sdram_a_t    sdram_a,
    output sdram_ba_t   sdram_ba,
    output logic        sdram_dqml,
    output logic        sdram_dqmh,
    output logic        sdram_nwe,
    output logic        sdram_ncas,
    output logic        sdram_nras,
    output logic        sdram_ncs,
    output logic        sdram_cke
);
    logic       init;
    sdram_cmd_t init_cmd;
    sdram_a_t   init_a;
    sdram_cmd_t cmd;
    logic [3:0] bank_dbusy;
    logic [3:0] bank_post_act;
    logic       data_busy;
    logic       act_recent;
    logic       dq_oe;
    logic       wr_tail;     // second word of a write burst
    req_addr_t  bank_addr [4];

    sdram_bus_if bus [4] ();

    assign bank_addr[0] = ba0_addr;
    assign bank_addr[1] = ba1_addr;
    assign bank_addr[2] = ba2_addr;
    assign bank_addr[3] = ba3_addr;

    sdram_init u_init (
        .clk  (clk),
        .rst  (rst),
        .init (init),
        .cmd  (init_cmd),
        .a    (init_a)
    );

    for (genvar i = 0; i < 4; i++) begin : g_bank
        sdram_bank u_bank (
            .clk        (clk),
            .rst        (rst),
            .addr       (bank_addr[i]),
            .rd         (rd[i]),
            .wr         (wr[i]),
            .ack        (ack[i]),
            .dst        (dst[i]),
            .dok        (dok[i]),
            .rdy        (rdy[i]),
            .dbusy      (bank_dbusy[i]),
            .post_act   (bank_post_act[i]),
            .data_busy  (data_busy),
            .act_recent (act_recent),
            .bus        (bus[i])
        );
    end

    sdram_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .init       (init),
        .init_cmd   (init_cmd),
        .init_a     (init_a),
        .bus        (bus),
        .dbusy      (bank_dbusy),
        .post_act   (bank_post_act),
        .data_busy  (data_busy),
        .act_recent (act_recent),
        .cmd        (cmd),
        .sdram_a    (sdram_a),
        .sdram_ba   (sdram_ba)
    );

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;
    assign sdram_cke = 1'b1;

    // write data and its byte mask go out with the WRITE command
    assign dq_oe    = cmd == WRITE;
    assign sdram_dq = dq_oe ? din : 'z;
    assign {sdram_dqmh, sdram_dqml} = sdram_a[12:11] | (dq_oe ? din_m : 2'b00) | {2{wr_tail}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_tail <= 1'b0;
        end else begin
            wr_tail <= dq_oe;
        end
    end

    always_ff @(posedge clk) begin
        dout <= sdram_dq;
    end

endmodule

`default_nettype wire

//--- source/sdram_init.sv
// power-up command sequencer
`default_nettype none
`include "sdram_config.svh"

module sdram_init
    import sdram_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    output logic       init,
    output sdram_cmd_t cmd,
    output sdram_a_t   a
);
    localparam int T_PRE  = `SDRAM_INIT_WAIT;
    localparam int T_REF0 = T_PRE + `SDRAM_TRP;
    localparam int T_REF1 = T_REF0 + `SDRAM_TRFC;
    localparam int T_MODE = T_REF1 + `SDRAM_TRFC;
    localparam int T_END  = T_MODE + 3;  // mode register settles first
    localparam int CW     = $clog2(T_END + 1);

    logic [CW-1:0] cnt;

    assign init = cnt != CW'(T_END);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (init) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        cmd = NOP;
        a   = '0;
        if (cnt == CW'(T_PRE)) begin
            cmd   = PRECHARGE;
            a[10] = 1'b1;  // all banks
        end else if (cnt == CW'(T_REF0) || cnt == CW'(T_REF1)) begin
            cmd = REFRESH;
        end else if (cnt == CW'(T_MODE)) begin
            cmd = LOAD_MODE;
            a   = `SDRAM_MODE;
        end
    end

endmodule

`default_nettype wire

//--- testbench/sdram_model.sv
// behavioral SDR SDRAM
`default_nettype none
`include "sdram_config.svh"

module sdram_model
    import sdram_cmd_pkg::*;
(
    input  wire        clk,
    inout  wire [15:0] dq,
    input  sdram_a_t   a,
    input  sdram_ba_t  ba,
    input  wire        dqml,
    input  wire        dqmh,
    input  wire        nwe,
    input  wire        ncas,
    input  wire        nras,
    input  wire        ncs,
    input  wire        cke,
    output logic       mode_loaded,
    output logic       proto_err
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CL = `SDRAM_CL;

    logic [15:0]   mem [logic [23:0]];  // key is bank, row, column
    logic [12:0]   open_row [4];
    logic [3:0]    is_open;
    int            act_cyc [4];
    int            cyc;
    logic [CL-1:0] rd_pend;             // read burst in flight
    logic [23:0]   rd_key;
    logic          wr_pend;             // second word of a write burst
    logic [23:0]   wr_key;
    logic          dq_oe;
    logic [15:0]   dq_out;
    sdram_cmd_t    cmd;

    assign dq  = dq_oe ? dq_out : 'z;
    assign cmd = ncs ? INHIBIT : sdram_cmd_t'({ncs, nras, ncas, nwe});

    // content of a word never written
    function automatic logic [15:0] unwritten_word(logic [23:0] key);
        logic [31:0] h;
        h = {8'h00, key} * 32'h9e3779b1;
        return h[31:16] ^ key[15:0];
    endfunction

    function automatic logic [15:0] read_word(logic [23:0] key);
        return mem.exists(key) ? mem[key] : unwritten_word(key);
    endfunction

    // mask bit set keeps the old byte
    task automatic write_word(logic [23:0] key, logic [15:0] data, logic [1:0] mask);
        logic [15:0] w;
        w = read_word(key);
        if (!mask[0]) w[7:0] = data[7:0];
        if (!mask[1]) w[15:8] = data[15:8];
        mem[key] = w;
    endtask

    task automatic flag(string msg);
        $display("SDRAM model error at cycle %0d: %s", cyc, msg);
        proto_err = 1'b1;
    endtask

    initial begin
        mode_loaded = 1'b0;
        proto_err   = 1'b0;
        is_open     = '0;
        rd_pend     = '0;
        wr_pend     = 1'b0;
        dq_oe       = 1'b0;
        dq_out      = '0;
        cyc         = 0;
    end

    always @(posedge clk) begin
        logic [23:0] key;
        cyc++;
        key = {ba, open_row[ba], a[8:0]};
        if (cke !== 1'b1) flag("clock enable not high");
        if (dq_oe && cmd == WRITE) flag("dq driven by both sides");
        // read data CL cycles after READ, then the second word
        dq_oe <= rd_pend[CL-2] | rd_pend[CL-1];
        if (rd_pend[CL-2]) dq_out <= read_word(rd_key);
        if (rd_pend[CL-1]) dq_out <= read_word(rd_key ^ 24'd1);
        rd_pend <= {rd_pend[CL-2:0], cmd == READ};
        if (wr_pend) write_word(wr_key, dq, {dqmh, dqml});
        wr_pend <= cmd == WRITE;
        if (!mode_loaded && !(cmd inside {NOP, PRECHARGE, REFRESH, LOAD_MODE, INHIBIT})) begin
            flag("command other than NOP, PRECHARGE or REFRESH before mode load");
        end
        case (cmd)
            LOAD_MODE: begin
                if (a != `SDRAM_MODE) flag("wrong mode register value");
                mode_loaded <= 1'b1;
            end
            ACTIVE: begin
                if (is_open[ba]) flag("ACTIVE to an open bank");
                is_open[ba]  <= 1'b1;
                open_row[ba] <= a;
                act_cyc[ba]  = cyc;
            end
            PRECHARGE: begin
                if (a[10]) is_open <= '0;
                else is_open[ba] <= 1'b0;
            end
            READ, WRITE: begin
                if (!is_open[ba]) flag("column command to a closed bank");
                else if (cyc - act_cyc[ba] < `SDRAM_TRCD) flag("column command before tRCD");
                if (a[10]) is_open[ba] <= 1'b0;  // auto-precharge
                if (cmd == READ) begin
                    rd_key <= key;
                end else begin
                    write_word(key, dq, {dqmh, dqml});
                    wr_key <= key ^ 24'd1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// testbench clock and reset
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #10 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
// SDRAM controller testbench
`default_nettype none
`include "sdram_config.svh"

module tb_top
    import sdram_cmd_pkg::*;
    import sdram_bank_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_OPS = 400;
    localparam int LIMIT = `SDRAM_INIT_WAIT + 60 + N_OPS * 40;

    logic       clk;
    logic       rst;
    req_addr_t  addr_in [4];
    logic [3:0] rd;
    logic [3:0] wr;
    sdram_dq_t  din;
    wmask_t     din_m;
    logic [3:0] ack;
    logic [3:0] dst;
    logic [3:0] dok;
    logic [3:0] rdy;
    sdram_dq_t  dout;
    wire [15:0] dq;
    sdram_a_t   a;
    sdram_ba_t  ba;
    logic       dqml;
    logic       dqmh;
    logic       nwe;
    logic       ncas;
    logic       nras;
    logic       ncs;
    logic       cke;
    logic       mode_loaded;
    logic       proto_err;

    logic [15:0] shadow [logic [23:0]];  // bank, row, column
    logic [3:0]  pend;
    logic [3:0]  acked;
    logic [3:0]  dst_seen;
    logic [3:0]  op_wr;
    int          nword [4];
    sdram_dq_t   exp_word [4][2];
    int          n_ops;
    int          n_acks;
    int          n_rdys;
    int          cycles;

    tb_clock u_clock (.clk(clk), .rst(rst));

    sdram_ctrl dut (
        .clk(clk), .rst(rst),
        .ba0_addr(addr_in[0]), .ba1_addr(addr_in[1]),
        .ba2_addr(addr_in[2]), .ba3_addr(addr_in[3]),
        .rd(rd), .wr(wr), .din(din), .din_m(din_m),
        .ack(ack), .dst(dst), .dok(dok), .rdy(rdy), .dout(dout),
        .sdram_dq(dq), .sdram_a(a), .sdram_ba(ba),
        .sdram_dqml(dqml), .sdram_dqmh(dqmh), .sdram_nwe(nwe),
        .sdram_ncas(ncas), .sdram_nras(nras), .sdram_ncs(ncs), .sdram_cke(cke)
    );

    sdram_model u_model (
        .clk(clk), .dq(dq), .a(a), .ba(ba), .dqml(dqml), .dqmh(dqmh),
        .nwe(nwe), .ncas(ncas), .nras(nras), .ncs(ncs), .cke(cke),
        .mode_loaded(mode_loaded), .proto_err(proto_err)
    );

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [15:0] unwritten_word(logic [23:0] key);
        logic [31:0] h;
        h = {8'h00, key} * 32'h9e3779b1;
        return h[31:16] ^ key[15:0];
    endfunction

    function automatic logic [15:0] shadow_word(logic [23:0] key);
        return shadow.exists(key) ? shadow[key] : unwritten_word(key);
    endfunction

    // 16 addresses per bank, even columns only
    function automatic req_addr_t addr_of(int k);
        return {13'(k / 4 * 37 + 5), 9'(k % 4 * 2 + 16)};
    endfunction

    task automatic start_op(int i);
        int          op;
        req_addr_t   ad;
        logic [23:0] key;
        logic [15:0] old;
        op = $urandom_range(0, 4);  // 0 idle, 1..2 read, 3..4 write
        if (op != 0) begin
            ad          = addr_of($urandom_range(0, 15));
            key         = {2'(i), ad};
            addr_in[i]  = ad;
            pend[i]     = 1'b1;
            acked[i]    = 1'b0;
            dst_seen[i] = 1'b0;
            nword[i]    = 0;
            op_wr[i]    = op > 2;
            n_ops++;
            if (op > 2) begin
                old         = shadow_word(key);
                shadow[key] = {din_m[1] ? old[15:8] : din[15:8], din_m[0] ? old[7:0] : din[7:0]};
                wr[i]       = 1'b1;
            end else begin
                exp_word[i][0] = shadow_word(key);
                exp_word[i][1] = shadow_word(key | 24'd1);
                rd[i]          = 1'b1;
            end
        end
    endtask

    task automatic check_port(int i);
        if (!pend[i]) begin
            assert (!ack[i] && !dst[i] && !dok[i] && !rdy[i])
            else stop_with_error($sformatf("port %0d: strobe without a request", i));
        end else begin
            if (ack[i]) begin
                assert (!acked[i]) else stop_with_error($sformatf("port %0d: second ack", i));
                acked[i] = 1'b1;
                rd[i]    = 1'b0;
                wr[i]    = 1'b0;
                n_acks++;
            end
            if (dst[i]) begin
                assert (acked[i] && nword[i] == 0 && !dst_seen[i])
                else stop_with_error($sformatf("port %0d: dst out of place", i));
                dst_seen[i] = 1'b1;
            end
            if (dok[i]) begin
                assert (acked[i]) else stop_with_error($sformatf("port %0d: dok before ack", i));
                if (nword[i] == 0) begin
                    // read data is announced a cycle early, write data in the same cycle
                    assert (dst_seen[i] && (op_wr[i] || !dst[i]))
                    else stop_with_error($sformatf("port %0d: no dst ahead of the first word", i));
                end
                if (!op_wr[i]) begin
                    assert (nword[i] < 2)
                    else stop_with_error($sformatf("port %0d: more than two data cycles", i));
                    assert (dout == exp_word[i][nword[i]])
                    else stop_with_error($sformatf("MISMATCH dout port %0d word %0d: got %h expected %h",
                                                   i, nword[i], dout, exp_word[i][nword[i]]));
                end
                nword[i]++;
            end
            if (rdy[i]) begin
                assert (acked[i] && nword[i] == (op_wr[i] ? 1 : 2))
                else stop_with_error($sformatf("port %0d: rdy after %0d data cycles", i, nword[i]));
                pend[i] = 1'b0;
                n_rdys++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            stop_with_error($sformatf("timeout: requests still open after %0d cycles", cycles));
        end
    end

    initial begin
        void'($urandom(32'hf39f487e));
        rd       = '0;
        wr       = '0;
        din      = '0;
        din_m    = '0;
        pend     = '0;
        acked    = '0;
        dst_seen = '0;
        op_wr    = '0;
        n_ops    = 0;
        n_acks   = 0;
        n_rdys   = 0;
        cycles   = 0;
        for (int i = 0; i < 4; i++) addr_in[i] = '0;
        @(negedge rst);
        // requests go out during init, so the first round also covers it
        while (n_ops < N_OPS) begin
            @(posedge clk);
            #10;
            for (int i = 0; i < 4; i++) check_port(i);  // quiet cycle between rounds
            din   = 16'($urandom);  // shared by every write of the round
            din_m = 2'($urandom);
            for (int i = 0; i < 4; i++) begin
                if (n_ops < N_OPS) start_op(i);
            end
            while (pend != 0) begin
                @(posedge clk);
                #10;
                assert (!proto_err) else stop_with_error("SDRAM model reported a protocol error");
                if (!mode_loaded) begin
                    assert (ack == 0 && dok == 0 && rdy == 0)
                    else stop_with_error("strobe before initialization finished");
                end
                for (int i = 0; i < 4; i++) check_port(i);
            end
        end
        if (n_acks == N_OPS && n_rdys == N_OPS) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_with_error($sformatf("request count off: %0d acks, %0d rdys", n_acks, n_rdys));
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/sdram_cmd_pkg.sv
source/sdram_bank_pkg.sv
source/sdram_bus_if.sv
source/sdram_init.sv
source/sdram_bank.sv
source/sdram_arbiter.sv
source/sdram_ctrl.sv
testbench/tb_clock.sv
testbench/sdram_model.sv
testbench/tb_top.sv
